// ==== mem_stage_cfg.svh ====
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// Datapath widths, fixed by RV32
`define MEM_XLEN   32
`define MEM_RD_W   5
`define MEM_STRB_W 4

// Result source codes as decoded upstream
`define MEM_RES_ALU 3'b000
`define MEM_RES_MEM 3'b001
`define MEM_RES_PC4 3'b010
`define MEM_RES_TGT 3'b011
`define MEM_RES_M   3'b100

// Trap cause raised by this stage
`define MEM_TRAP_LDST_MISALIGN 2'b10

// Access size in funct3[1:0]
`define MEM_SZ_B 2'b00
`define MEM_SZ_H 2'b01
`define MEM_SZ_W 2'b10

// funct3[2] set means LBU/LHU
`define MEM_LD_UNSIGNED_BIT 2

`endif

// ==== mem_stage_pkg.sv ====
`default_nettype none

`include "mem_stage_cfg.svh"

package mem_stage_pkg;

  // Basic vector types
  typedef logic [`MEM_XLEN-1:0]   xlen_t;
  typedef logic [`MEM_RD_W-1:0]   reg_idx_t;
  typedef logic [`MEM_STRB_W-1:0] strb_t;
  typedef logic [2:0]             funct3_t;
  typedef logic [2:0]             res_src_t;
  typedef logic [1:0]             trap_code_t;

  // Execute stage to memory stage
  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    res_src_t   res_src;
    reg_idx_t   rd;
    funct3_t    funct3;
    xlen_t      alu_result;  // also the effective address
    xlen_t      rs2_data;    // store data
    xlen_t      pc_plus4;
    xlen_t      jb_tgt;
    xlen_t      m_result;
    logic       trap;
    trap_code_t trap_code;
  } mem_op_t;

  // SRAM-style data memory port, read data returns same cycle
  typedef struct packed {
    logic  ren;
    xlen_t raddr;
    logic  we;
    xlen_t waddr;
    xlen_t wdata;
    strb_t wstrb;
  } dmem_req_t;

  // Memory stage to write-back stage
  typedef struct packed {
    logic       reg_write;
    logic       trap;
    trap_code_t trap_code;
    res_src_t   res_src;
    reg_idx_t   rd;
    funct3_t    funct3;
    xlen_t      alu_result;
    xlen_t      ld_data;
    xlen_t      pc_plus4;
    xlen_t      jb_tgt;
    xlen_t      m_result;
  } wb_bundle_t;

endpackage

`default_nettype wire

// ==== mem_store_fmt.sv ====
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_store_fmt (
  input  mem_stage_pkg::funct3_t funct3_i,
  input  logic [1:0]             addr_lo_i,
  input  mem_stage_pkg::xlen_t   data_i,
  output mem_stage_pkg::xlen_t   wdata_o,
  output mem_stage_pkg::strb_t   wstrb_o
);

  // ================================================
  // Lane replication
  // ================================================

  // Memory picks the live lanes from the strobes, so the source
  // byte or halfword is copied to every lane it could land in
  always_comb begin
    case (funct3_i[1:0])
      `MEM_SZ_B: begin
        wdata_o = {4{data_i[7:0]}};
      end
      `MEM_SZ_H: begin
        wdata_o = {2{data_i[15:0]}};
      end
      default: begin
        wdata_o = data_i;
      end
    endcase
  end

  // ================================================
  // Byte strobes
  // ================================================

  always_comb begin
    case (funct3_i[1:0])
      `MEM_SZ_B: begin
        // One lane at the byte offset
        wstrb_o = mem_stage_pkg::strb_t'(1) << addr_lo_i;
      end
      `MEM_SZ_H: begin
        // Upper or lower half, bit 0 is a misalignment and ignored here
        if (addr_lo_i[1]) begin
          wstrb_o = 4'b1100;
        end else begin
          wstrb_o = 4'b0011;
        end
      end
      default: begin
        // Word store, all lanes
        wstrb_o = '1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== mem_load_fmt.sv ====
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_load_fmt (
  input  mem_stage_pkg::funct3_t funct3_i,
  input  logic [1:0]             addr_lo_i,
  input  mem_stage_pkg::xlen_t   rdata_i,
  output mem_stage_pkg::xlen_t   data_o
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic        unsigned_ld;
  logic        byte_sign;
  logic        half_sign;

  // ================================================
  // Lane select
  // ================================================

  // Addressed byte from the aligned read word
  always_comb begin
    case (addr_lo_i)
      2'd0: byte_sel = rdata_i[7:0];
      2'd1: byte_sel = rdata_i[15:8];
      2'd2: byte_sel = rdata_i[23:16];
      default: byte_sel = rdata_i[31:24];
    endcase
  end

  // Halfword by address bit 1
  assign half_sel = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

  // ================================================
  // Extension
  // ================================================

  // LBU and LHU zero extend
  assign unsigned_ld = funct3_i[`MEM_LD_UNSIGNED_BIT];

  // Fill bit, forced low for unsigned loads
  assign byte_sign = byte_sel[7] & ~unsigned_ld;
  assign half_sign = half_sel[15] & ~unsigned_ld;

  always_comb begin
    case (funct3_i[1:0])
      `MEM_SZ_B: begin
        data_o = {{(`MEM_XLEN - 8){byte_sign}}, byte_sel};
      end
      `MEM_SZ_H: begin
        data_o = {{(`MEM_XLEN - 16){half_sign}}, half_sel};
      end
      default: begin
        // LW, returned as read
        data_o = rdata_i;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== mem_access_ctrl.sv ====
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_access_ctrl (
  input  logic                     s_valid_i,
  input  logic                     stall_i,
  input  mem_stage_pkg::mem_op_t   op_i,
  output mem_stage_pkg::dmem_req_t dmem_req_o,
  output logic                     trap_o,
  output mem_stage_pkg::trap_code_t trap_code_o
);

  logic                 is_mem;
  logic                 misalign;
  logic                 req_en;
  mem_stage_pkg::xlen_t word_addr;
  mem_stage_pkg::xlen_t st_wdata;
  mem_stage_pkg::strb_t st_wstrb;

  // ================================================
  // Misalignment check
  // ================================================

  assign is_mem = op_i.mem_read | op_i.mem_write;

  // Bytes never misalign; halfwords need bit 0 clear,
  // words need both low bits clear
  always_comb begin
    misalign = 1'b0;
    if (is_mem) begin
      case (op_i.funct3[1:0])
        `MEM_SZ_H: misalign = op_i.alu_result[0];
        `MEM_SZ_W: misalign = |op_i.alu_result[1:0];
        default:   misalign = 1'b0;
      endcase
    end
  end

  // Upstream traps keep their own cause
  assign trap_o      = op_i.trap | misalign;
  assign trap_code_o = misalign ? `MEM_TRAP_LDST_MISALIGN : op_i.trap_code;

  // ================================================
  // Store formatting
  // ================================================

  mem_store_fmt u_store_fmt (
    .funct3_i  (op_i.funct3),
    .addr_lo_i (op_i.alu_result[1:0]),
    .data_i    (op_i.rs2_data),
    .wdata_o   (st_wdata),
    .wstrb_o   (st_wstrb)
  );

  // ================================================
  // Memory request
  // ================================================

  // No enables while stalled or for a trapping op
  assign req_en = s_valid_i & ~stall_i & ~trap_o;

  // Memory is word addressed, lane choice is in the strobes
  assign word_addr = {op_i.alu_result[`MEM_XLEN-1:2], 2'b00};

  always_comb begin
    dmem_req_o.ren   = req_en & op_i.mem_read;
    dmem_req_o.raddr = word_addr;
    dmem_req_o.we    = req_en & op_i.mem_write;
    dmem_req_o.waddr = word_addr;
    dmem_req_o.wdata = st_wdata;
    // Strobes only for stores
    dmem_req_o.wstrb = op_i.mem_write ? st_wstrb : '0;
  end

endmodule

`default_nettype wire

// ==== mem_wb_reg.sv ====
`default_nettype none

module mem_wb_reg (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      s_valid_i,
  input  logic                      stall_i,
  input  mem_stage_pkg::wb_bundle_t next_i,
  output logic                      m_valid_o,
  output mem_stage_pkg::wb_bundle_t wb_o
);

  logic                      advance;
  logic                      bubble;
  logic                      valid_q;
  logic                      reg_write_q;
  logic                      trap_q;
  mem_stage_pkg::wb_bundle_t payload_q;

  // ================================================
  // Flow control
  // ================================================

  // Stage always accepts, only a stall holds it
  assign advance = ~stall_i;

  // Advancing with nothing valid inserts a bubble
  assign bubble = advance & ~s_valid_i;

  // ================================================
  // Control flags
  // ================================================

  // Flags that trigger action downstream, cleared on a bubble
  // so write-back can use them without checking valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q     <= 1'b0;
      reg_write_q <= 1'b0;
      trap_q      <= 1'b0;
    end else if (bubble) begin
      valid_q     <= 1'b0;
      reg_write_q <= 1'b0;
      trap_q      <= 1'b0;
    end else if (advance) begin
      valid_q     <= 1'b1;
      reg_write_q <= next_i.reg_write;
      trap_q      <= next_i.trap;
    end
  end

  // ================================================
  // Payload
  // ================================================

  // Data fields load on every advance, stale after a bubble
  always_ff @(posedge clk) begin
    if (advance) begin
      payload_q <= next_i;
    end
  end

  // Flags from the control register override the payload copies
  always_comb begin
    wb_o           = payload_q;
    wb_o.reg_write = reg_write_q;
    wb_o.trap      = trap_q;
  end

  assign m_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_stage (
  input  logic                      clk,
  input  logic                      rst_n,

  // From execute
  input  logic                      s_valid_i,
  input  logic                      stall_i,
  input  mem_stage_pkg::mem_op_t    op_i,

  // Data memory, combinational read
  output mem_stage_pkg::dmem_req_t  dmem_req_o,
  input  mem_stage_pkg::xlen_t      dmem_rdata_i,

  // To write-back
  output logic                      m_valid_o,
  output mem_stage_pkg::wb_bundle_t wb_o,

  // Forwarding
  output mem_stage_pkg::xlen_t      result_o,
  output mem_stage_pkg::xlen_t      ld_data_o
);

  logic                       trap;
  mem_stage_pkg::trap_code_t  trap_code;
  mem_stage_pkg::xlen_t       ld_data;
  mem_stage_pkg::wb_bundle_t  next_wb;

  // ================================================
  // Access control and memory request
  // ================================================

  mem_access_ctrl u_access_ctrl (
    .s_valid_i   (s_valid_i),
    .stall_i     (stall_i),
    .op_i        (op_i),
    .dmem_req_o  (dmem_req_o),
    .trap_o      (trap),
    .trap_code_o (trap_code)
  );

  // ================================================
  // Load formatting
  // ================================================

  // Read data is same cycle, so format with current address
  mem_load_fmt u_load_fmt (
    .funct3_i  (op_i.funct3),
    .addr_lo_i (op_i.alu_result[1:0]),
    .rdata_i   (dmem_rdata_i),
    .data_o    (ld_data)
  );

  assign ld_data_o = ld_data;

  // ================================================
  // Forwarding result
  // ================================================

  // Loads forward through ld_data_o, so RES_MEM falls to the ALU value
  always_comb begin
    case (op_i.res_src)
      `MEM_RES_M:   result_o = op_i.m_result;
      `MEM_RES_PC4: result_o = op_i.pc_plus4;
      `MEM_RES_TGT: result_o = op_i.jb_tgt;
      `MEM_RES_ALU,
      `MEM_RES_MEM: result_o = op_i.alu_result;
      default:      result_o = op_i.alu_result;
    endcase
  end

  // ================================================
  // Write-back bundle
  // ================================================

  always_comb begin
    // A trapping op must not write the register file
    next_wb.reg_write  = op_i.reg_write & ~trap;
    next_wb.trap       = trap;
    next_wb.trap_code  = trap_code;
    next_wb.res_src    = op_i.res_src;
    next_wb.rd         = op_i.rd;
    next_wb.funct3     = op_i.funct3;
    next_wb.alu_result = op_i.alu_result;
    next_wb.ld_data    = ld_data;
    next_wb.pc_plus4   = op_i.pc_plus4;
    next_wb.jb_tgt     = op_i.jb_tgt;
    next_wb.m_result   = op_i.m_result;
  end

  mem_wb_reg u_wb_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_valid_i (s_valid_i),
    .stall_i   (stall_i),
    .next_i    (next_wb),
    .m_valid_o (m_valid_o),
    .wb_o      (wb_o)
  );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // 100 ns period
  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Reset low for the first cycles, released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_dmem_model.sv ====
`default_nettype none

module tb_dmem_model (
  input  logic                     clk_i,
  input  mem_stage_pkg::dmem_req_t req_i,
  output mem_stage_pkg::xlen_t     rdata_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH = 256;

  // Word storage, preloaded by the testbench
  mem_stage_pkg::xlen_t mem [0:DEPTH-1];

  // ================================================
  // Read port
  // ================================================

  // SRAM-style, data for the current address in the same cycle
  assign rdata_o = mem[req_i.raddr[9:2]];

  // ================================================
  // Write port
  // ================================================

  // Only lanes with a strobe change
  always @(posedge clk_i) begin
    if (req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.wstrb[b]) begin
          mem[req_i.waddr[9:2]][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_mem_stage.sv ====
`default_nettype none

`include "mem_stage_cfg.svh"

module tb_mem_stage;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 8;
  localparam int RAND_OPS   = 60;

  logic                      clk;
  logic                      rst_n;
  logic                      s_valid;
  logic                      stall;
  mem_stage_pkg::mem_op_t    op;
  mem_stage_pkg::dmem_req_t  dmem_req;
  mem_stage_pkg::xlen_t      dmem_rdata;
  logic                      m_valid;
  mem_stage_pkg::wb_bundle_t wb;
  mem_stage_pkg::xlen_t      result;
  mem_stage_pkg::xlen_t      ld_data;

  string                     cur_test;
  int                        write_count = 0;
  integer                    seed;
  // Expected memory contents
  mem_stage_pkg::xlen_t      shadow [0:255];

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mem_stage u_mem_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_valid_i    (s_valid),
    .stall_i      (stall),
    .op_i         (op),
    .dmem_req_o   (dmem_req),
    .dmem_rdata_i (dmem_rdata),
    .m_valid_o    (m_valid),
    .wb_o         (wb),
    .result_o     (result),
    .ld_data_o    (ld_data)
  );

  tb_dmem_model u_dmem (
    .clk_i   (clk),
    .req_i   (dmem_req),
    .rdata_o (dmem_rdata)
  );

  // Writes as the memory sees them at the edge
  always @(posedge clk) begin
    if (dmem_req.we) begin
      write_count <= write_count + 1;
    end
  end

  // ================================================
  // Reporting
  // ================================================

  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check(input string what, input logic [191:0] exp, input logic [191:0] act);
    if (act !== exp) begin
      $display("error: %s %s expected %0h actual %0h", cur_test, what, exp, act);
      stop_on_error();
    end
  endtask

  // ================================================
  // Expected values
  // ================================================

  function automatic int size_bytes(input logic [1:0] sz);
    case (sz)
      `MEM_SZ_B: return 1;
      `MEM_SZ_H: return 2;
      default:   return 4;
    endcase
  endfunction

  // Each lane repeats the source bytes in order
  function automatic mem_stage_pkg::xlen_t exp_wdata(input logic [1:0] sz,
                                                     input mem_stage_pkg::xlen_t data);
    mem_stage_pkg::xlen_t w;
    int                   n;
    n = size_bytes(sz);
    for (int b = 0; b < 4; b++) begin
      w[8*b +: 8] = data[8*(b % n) +: 8];
    end
    return w;
  endfunction

  // One strobe per byte touched, starting at the offset
  function automatic mem_stage_pkg::strb_t exp_wstrb(input logic [1:0] sz, input logic [1:0] off);
    mem_stage_pkg::strb_t s;
    s = '0;
    for (int k = 0; k < size_bytes(sz); k++) begin
      s[off + k] = 1'b1;
    end
    return s;
  endfunction

  // Shift the addressed bytes down, then fill the top
  function automatic mem_stage_pkg::xlen_t exp_load(input mem_stage_pkg::funct3_t f3,
                                                    input logic [1:0] off,
                                                    input mem_stage_pkg::xlen_t word);
    mem_stage_pkg::xlen_t raw;
    logic                 fill;
    int                   n;
    n = size_bytes(f3[1:0]);
    raw = word >> (8 * off);
    if (n == 4) begin
      return word;
    end
    fill = ~f3[`MEM_LD_UNSIGNED_BIT] & raw[8*n-1];
    for (int k = 31; k >= 8 * n; k--) begin
      raw[k] = fill;
    end
    return raw;
  endfunction

  function automatic mem_stage_pkg::xlen_t exp_result(input mem_stage_pkg::mem_op_t o);
    case (o.res_src)
      `MEM_RES_M:   return o.m_result;
      `MEM_RES_PC4: return o.pc_plus4;
      `MEM_RES_TGT: return o.jb_tgt;
      default:      return o.alu_result;
    endcase
  endfunction

  // Byte merge of a store into the expected memory
  function automatic void shadow_store(input mem_stage_pkg::xlen_t addr, input logic [1:0] sz,
                                       input mem_stage_pkg::xlen_t data);
    for (int k = 0; k < size_bytes(sz); k++) begin
      shadow[addr[9:2]][8*(addr[1:0] + k) +: 8] = data[8*k +: 8];
    end
  endfunction

  // Initial word, distinct for every index
  function automatic mem_stage_pkg::xlen_t fill_word(input int i);
    logic [7:0] a;
    a = i[7:0];
    return {a ^ 8'hc3, ~a, a + 8'h29, a};
  endfunction

  function automatic mem_stage_pkg::mem_op_t mem_op(input logic wr,
                                                    input mem_stage_pkg::funct3_t f3,
                                                    input mem_stage_pkg::xlen_t addr,
                                                    input mem_stage_pkg::xlen_t data);
    mem_stage_pkg::mem_op_t o;
    o            = '0;
    o.reg_write  = ~wr;
    o.mem_read   = ~wr;
    o.mem_write  = wr;
    o.res_src    = wr ? `MEM_RES_ALU : `MEM_RES_MEM;
    o.rd         = 5'd9;
    o.funct3     = f3;
    o.alu_result = addr;
    o.rs2_data   = data;
    return o;
  endfunction

  // ================================================
  // Driving and waiting
  // ================================================

  // New inputs at the rising edge, sampled at the falling edge
  task automatic drive(input mem_stage_pkg::mem_op_t o, input logic v, input logic st);
    @(posedge clk);
    op      <= o;
    s_valid <= v;
    stall   <= st;
    @(negedge clk);
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    while (!m_valid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!m_valid) begin
      $display("%s: stage gave no valid output within %0d cycles", cur_test, WAIT_LIMIT);
      stop_on_error();
    end
  endtask

  // Idle input so the previous op moves into the register
  task automatic retire();
    drive('0, 1'b0, 1'b0);
    wait_valid();
  endtask

  // One aligned load or store, held by a stall first if asked
  task automatic access(input logic wr, input mem_stage_pkg::funct3_t f3,
                        input mem_stage_pkg::xlen_t addr, input mem_stage_pkg::xlen_t data,
                        input int stalls);
    mem_stage_pkg::mem_op_t o;
    mem_stage_pkg::xlen_t   exp_ld;
    int                     idx;
    int                     base;
    o   = mem_op(wr, f3, addr, data);
    idx = addr[9:2];
    for (int s = 0; s < stalls; s++) begin
      drive(o, 1'b1, 1'b1);
      check("enables under stall", 2'b00, {dmem_req.ren, dmem_req.we});
    end
    drive(o, 1'b1, 1'b0);
    base = write_count;
    check("enables", {~wr, wr}, {dmem_req.ren, dmem_req.we});
    check("word address", {addr[31:2], 2'b00}, wr ? dmem_req.waddr : dmem_req.raddr);
    if (wr) begin
      check("wdata", exp_wdata(f3[1:0], data), dmem_req.wdata);
      check("wstrb", exp_wstrb(f3[1:0], addr[1:0]), dmem_req.wstrb);
      shadow_store(addr, f3[1:0], data);
    end else begin
      exp_ld = exp_load(f3, addr[1:0], shadow[idx]);
      check("wstrb on load", 4'h0, dmem_req.wstrb);
      check("ld_data_o", exp_ld, ld_data);
    end
    retire();
    check("trap", 1'b0, wb.trap);
    check("reg_write", !wr, wb.reg_write);
    check("write count", wr, write_count - base);
    check("memory word", shadow[idx], u_dmem.mem[idx]);
    if (!wr) begin
      check("wb ld_data", exp_ld, wb.ld_data);
    end
  endtask

  // Op that must trap with the given code and leave memory alone
  task automatic trap_op(input mem_stage_pkg::mem_op_t o, input logic [1:0] code);
    int base;
    drive(o, 1'b1, 1'b0);
    base = write_count;
    check("enables on trap", 2'b00, {dmem_req.ren, dmem_req.we});
    retire();
    check("trap", 1'b1, wb.trap);
    check("trap_code", code, wb.trap_code);
    check("reg_write on trap", 1'b0, wb.reg_write);
    check("write count on trap", 0, write_count - base);
    check("memory untouched", shadow[o.alu_result[9:2]], u_dmem.mem[o.alu_result[9:2]]);
  endtask

  // ================================================
  // Tests
  // ================================================

  task automatic test_reset();
    int n;
    cur_test = "reset";
    n = 0;
    while (!rst_n && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!rst_n) begin
      $display("reset never released");
      stop_on_error();
    end
    check("m_valid", 1'b0, m_valid);
    check("reg_write", 1'b0, wb.reg_write);
    check("trap", 1'b0, wb.trap);
  endtask

  task automatic test_store_fmt();
    cur_test = "store_fmt";
    for (int off = 0; off < 4; off++) begin
      access(1'b1, {1'b0, `MEM_SZ_B}, 32'h40 + off, 32'h8ba4_1f50 + off, 0);
    end
    for (int off = 0; off < 4; off += 2) begin
      access(1'b1, {1'b0, `MEM_SZ_H}, 32'h44 + off, 32'h3e71_c0a2 + off, 0);
    end
    access(1'b1, {1'b0, `MEM_SZ_W}, 32'h48, 32'hd00d_2b6e, 0);
  endtask

  task automatic test_load_ext();
    mem_stage_pkg::funct3_t f3 [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    cur_test = "load_ext";
    // One word with high bits set in every lane, one with them clear
    shadow[32] = 32'hf08c_fa95;
    shadow[33] = 32'h0f73_057a;
    u_dmem.mem[32] = shadow[32];
    u_dmem.mem[33] = shadow[33];
    for (int i = 0; i < 5; i++) begin
      for (int a = 32'h80; a < 32'h88; a += size_bytes(f3[i][1:0])) begin
        access(1'b0, f3[i], a, 32'h0, 0);
      end
    end
  endtask

  task automatic test_misalign();
    mem_stage_pkg::mem_op_t o;
    cur_test = "misalign";
    trap_op(mem_op(1'b0, 3'b001, 32'hc1, 0), `MEM_TRAP_LDST_MISALIGN);
    trap_op(mem_op(1'b0, 3'b101, 32'hc3, 0), `MEM_TRAP_LDST_MISALIGN);
    for (int off = 1; off < 4; off++) begin
      trap_op(mem_op(1'b0, 3'b010, 32'hc4 + off, 0), `MEM_TRAP_LDST_MISALIGN);
      trap_op(mem_op(1'b1, 3'b010, 32'hc8 + off, 32'hffff_ffff), `MEM_TRAP_LDST_MISALIGN);
    end
    trap_op(mem_op(1'b1, 3'b001, 32'hcd, 32'h1234_5678), `MEM_TRAP_LDST_MISALIGN);
    // Trap from an earlier stage keeps its own code
    o           = mem_op(1'b0, 3'b010, 32'hd0, 0);
    o.trap      = 1'b1;
    o.trap_code = 2'b01;
    trap_op(o, 2'b01);
  endtask

  task automatic test_forward();
    mem_stage_pkg::mem_op_t o;
    cur_test = "forward";
    // Non-memory ops, odd addresses with halfword or word sizes must not trap
    for (int code = 0; code < 8; code++) begin
      o            = '0;
      o.reg_write  = 1'b1;
      o.res_src    = code[2:0];
      o.rd         = 5'd16 + code[4:0];
      o.funct3     = code[2:0];
      o.alu_result = 32'ha11a_0000 + code;
      o.pc_plus4   = 32'h0000_4004 + code;
      o.jb_tgt     = 32'h7e57_0800 + code;
      o.m_result   = 32'h5a5a_9000 + code;
      drive(o, 1'b1, 1'b0);
      check("result_o", exp_result(o), result);
      check("enables", 2'b00, {dmem_req.ren, dmem_req.we});
      retire();
      // Payload passes through to write-back unchanged
      check("wb trap", 1'b0, wb.trap);
      check("wb reg_write", 1'b1, wb.reg_write);
      check("wb res_src", o.res_src, wb.res_src);
      check("wb rd", o.rd, wb.rd);
      check("wb funct3", o.funct3, wb.funct3);
      check("wb alu_result", o.alu_result, wb.alu_result);
      check("wb pc_plus4", o.pc_plus4, wb.pc_plus4);
      check("wb jb_tgt", o.jb_tgt, wb.jb_tgt);
      check("wb m_result", o.m_result, wb.m_result);
    end
  endtask

  task automatic test_stall();
    mem_stage_pkg::mem_op_t    ld;
    mem_stage_pkg::mem_op_t    st;
    mem_stage_pkg::wb_bundle_t held;
    int                        base;
    cur_test = "stall";
    ld = mem_op(1'b0, 3'b010, 32'h90, 0);
    st = mem_op(1'b1, 3'b010, 32'h94, 32'h5eed_cafe);
    drive(ld, 1'b1, 1'b0);
    // Load is captured at this edge, the store waits behind the stall
    drive(st, 1'b1, 1'b1);
    wait_valid();
    held = wb;
    base = write_count;
    for (int k = 0; k < 3; k++) begin
      drive(st, 1'b1, 1'b1);
      check("enables under stall", 2'b00, {dmem_req.ren, dmem_req.we});
      check("m_valid hold", 1'b1, m_valid);
      check("bundle hold", held, wb);
    end
    drive(st, 1'b1, 1'b0);
    check("we after release", 1'b1, dmem_req.we);
    shadow_store(32'h94, `MEM_SZ_W, 32'h5eed_cafe);
    retire();
    check("writes after release", 1, write_count - base);
    check("memory word", shadow[37], u_dmem.mem[37]);
    // Bubble clears the flags of a register-writing load
    drive(ld, 1'b1, 1'b0);
    retire();
    check("reg_write before bubble", 1'b1, wb.reg_write);
    drive('0, 1'b0, 1'b0);
    check("m_valid on bubble", 1'b0, m_valid);
    check("reg_write on bubble", 1'b0, wb.reg_write);
    check("trap on bubble", 1'b0, wb.trap);
  endtask

  task automatic test_random();
    logic [31:0]          r;
    logic [1:0]           sz;
    logic [1:0]           off;
    mem_stage_pkg::xlen_t addr;
    int                   stalls;
    cur_test = "random";
    seed = 32'h4b4e_28b8;
    for (int i = 0; i < RAND_OPS; i++) begin
      r  = $random(seed);
      sz = (r[1:0] == 2'b11) ? `MEM_SZ_W : r[1:0];
      // Offset kept aligned to the access size
      case (sz)
        `MEM_SZ_B: off = r[9:8];
        `MEM_SZ_H: off = {r[9], 1'b0};
        default:   off = 2'b00;
      endcase
      addr   = 32'h100 + {r[7:4], 2'b00} + off;
      stalls = (r[11:10] == 2'b00) ? 1 + r[12] : 0;
      if (r[14]) begin
        access(1'b1, {1'b0, sz}, addr, $random(seed), stalls);
      end else begin
        access(1'b0, {r[15] & (sz != `MEM_SZ_W), sz}, addr, 32'h0, stalls);
      end
    end
  endtask

  // ================================================
  // Sequence
  // ================================================

  initial begin
    // Valid register-writing op held through reset
    s_valid      = 1'b1;
    stall        = 1'b0;
    op           = '0;
    op.reg_write = 1'b1;
    for (int i = 0; i < 256; i++) begin
      shadow[i]     = fill_word(i);
      u_dmem.mem[i] = shadow[i];
    end
    test_reset();
    test_store_fmt();
    test_load_ext();
    test_misalign();
    test_forward();
    test_stall();
    test_random();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
mem_stage_pkg.sv
mem_store_fmt.sv
mem_load_fmt.sv
mem_access_ctrl.sv
mem_wb_reg.sv
mem_stage.sv
tb_clk_gen.sv
tb_dmem_model.sv
tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mem_stage

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mem_stage_pkg.sv
      - mem_store_fmt.sv
      - mem_load_fmt.sv
      - mem_access_ctrl.sv
      - mem_wb_reg.sv
      - mem_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_dmem_model.sv
      - tb_mem_stage.sv
